// ==== bench/tb_dram_scrub.sv ====
/*
 * Directed testbench for the DRAM scrub control path.
 * Drives the top level on the falling clock edge, counts burst strobes
 * on rising edges and checks done flags, ID readout and the FLR pulse.
 * Each test is one task that prints a line when it ends.
 */

`timescale 1ns/1ps

module tb_dram_scrub;

   import scrub_pkg::*;

   localparam int          CLK_PERIOD            = 10;
   localparam int          NUM_CHAN              = 4;
   localparam logic [63:0] SCRB_MAX_ADDR         = 64'h1FFF;
   localparam int          SCRB_BURST_LEN_MINUS1 = 15;
   localparam logic [63:0] BURST_BYTES           =
      64'((SCRB_BURST_LEN_MINUS1 + 1) * BEAT_BYTES);

   // longest wait for a set of channels to finish
   localparam int DONE_WAIT   = 200;
   localparam int RUN_CYCLES  = 4 + 30 + (DONE_WAIT + 20) + (DONE_WAIT + 40) +
                                (DONE_WAIT + 20) + (2 * DONE_WAIT + 30) + 20;
   localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_PERIOD;

   logic                clk;
   logic                sync_rst_n;
   ctl_word_t           ctl0;
   logic [NUM_CHAN-1:0] ddr_is_ready;
   logic                flr_assert;
   logic                flr_done;
   logic [NUM_CHAN-1:0] scrb_burst;
   logic [NUM_CHAN-1:0] scrb_done;
   logic [ID_W-1:0]     id0;
   logic [ID_W-1:0]     id1;

   int          errors;
   int          tests_run;
   int          tests_failed;
   int          burst_cnt [NUM_CHAN];
   int          burst_base [NUM_CHAN];
   logic [31:0] seed;

   dram_scrub_top #(
      .NUM_CHAN              (NUM_CHAN),
      .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
      .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
   ) uut (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .scrb_burst   (scrb_burst),
      .scrb_done    (scrb_done),
      .id0          (id0),
      .id1          (id1)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #(CLK_PERIOD / 2) clk = ~clk;

   // strobes counted on the edge that sees them
   always @(posedge clk)
   begin
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         if (scrb_burst[i])
         begin
            burst_cnt[i]++;
         end
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   // ------------------------------------------------------------------------
   // expected values and helpers
   // ------------------------------------------------------------------------
   // last start address reached by stepping a full burst at a time
   function automatic logic [63:0] final_scrub_addr();
      logic [63:0] a;
      a = 64'd0;
      while (a + BURST_BYTES <= SCRB_MAX_ADDR)
      begin
         a = a + BURST_BYTES;
      end
      return a;
   endfunction

   // one strobe per start address, address 0 included
   function automatic int expected_bursts();
      return int'(final_scrub_addr() / BURST_BYTES) + 1;
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERROR at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic mark_bursts();
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         burst_base[i] = burst_cnt[i];
      end
   endtask

   task automatic check_bursts(input logic [NUM_CHAN-1:0] mask);
      int exp;
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         exp = mask[i] ? expected_bursts() : 0;
         check_value($sformatf("burst count ch%0d", i),
                     64'(burst_cnt[i] - burst_base[i]), 64'(exp));
      end
   endtask

   task automatic enable_channels(input logic [NUM_CHAN-1:0] mask);
      ctl0.chan_en = MAX_CHAN'(mask);
   endtask

   // waits on falling edges, optionally with new random ready bits each cycle
   task automatic wait_for_done(input logic [NUM_CHAN-1:0] mask, input int limit,
                                input logic shuffle_ready);
      int n;
      n = 0;
      while (((scrb_done & mask) != mask) && (n < limit))
      begin
         @(negedge clk);
         if (shuffle_ready)
         begin
            seed = lcg_next(seed);
            ddr_is_ready = seed[16 +: NUM_CHAN];
         end
         n++;
      end
      if ((scrb_done & mask) != mask)
      begin
         $display("ERROR at %0d ns: channels %b did not finish within %0d cycles",
                  $time, mask, limit);
         errors++;
      end
   endtask

   // back to idle, scrubbers return to address 0
   task automatic idle_inputs();
      ctl0         = '0;
      ddr_is_ready = '0;
      flr_assert   = 1'b0;
      repeat (3) @(negedge clk);
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests_run++;
      if (errors == err_start)
      begin
         $display("test %0d %s: passed", tests_run, name);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests_run, name,
                  errors - err_start);
      end
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   task automatic reset_state_test();
      int err_start;
      err_start = errors;
      check_value("id0", 64'(id0), 64'(DEV_ID0));
      check_value("id1", 64'(id1), 64'(DEV_ID1));
      check_value("scrb_done", 64'(scrb_done), 64'd0);
      check_value("scrb_burst", 64'(scrb_burst), 64'd0);
      check_value("flr_done", 64'(flr_done), 64'd0);
      // a channel scrubbing with debug off must not move the IDs
      ddr_is_ready = '1;
      enable_channels(NUM_CHAN'(8));
      repeat (12)
      begin
         @(negedge clk);
         check_value("id0", 64'(id0), 64'(DEV_ID0));
         check_value("id1", 64'(id1), 64'(DEV_ID1));
      end
      idle_inputs();
      finish_test("reset state", err_start);
   endtask

   task automatic single_channel_test();
      int          err_start;
      logic [63:0] last;
      err_start = errors;
      last = final_scrub_addr();
      mark_bursts();
      ddr_is_ready = '1;
      enable_channels(NUM_CHAN'(1));
      @(negedge clk);
      check_value("scrb_burst", 64'(scrb_burst), 64'd0);
      @(negedge clk);
      check_value("scrb_burst", 64'(scrb_burst), 64'd1);
      wait_for_done(NUM_CHAN'(1), DONE_WAIT, 1'b0);
      @(negedge clk);
      check_bursts(NUM_CHAN'(1));
      check_value("scrb_done", 64'(scrb_done), 64'd1);
      check_value("id0", 64'(id0), 64'(DEV_ID0));
      check_value("id1", 64'(id1), 64'(DEV_ID1));
      ctl0.dbg_en  = 1'b1;
      ctl0.dbg_sel = 3'd0;
      repeat (2) @(negedge clk);
      check_value("id0", 64'(id0), 64'(last[31:0]));
      check_value("id1", 64'(id1), 64'(last[63:32]));
      idle_inputs();
      finish_test("single channel scrub", err_start);
   endtask

   task automatic ready_low_test();
      int err_start;
      err_start = errors;
      mark_bursts();
      ddr_is_ready = '0;
      enable_channels(NUM_CHAN'(2));
      repeat (20)
      begin
         @(negedge clk);
         check_value("scrb_burst[1]", 64'(scrb_burst[1]), 64'd0);
         check_value("scrb_done[1]", 64'(scrb_done[1]), 64'd0);
      end
      ddr_is_ready = NUM_CHAN'(2);
      wait_for_done(NUM_CHAN'(2), DONE_WAIT, 1'b0);
      @(negedge clk);
      check_bursts(NUM_CHAN'(2));
      check_value("scrb_done", 64'(scrb_done), 64'd2);
      idle_inputs();
      finish_test("ready held low", err_start);
   endtask

   task automatic random_ready_test();
      int          err_start;
      logic [63:0] last;
      err_start = errors;
      last = final_scrub_addr();
      mark_bursts();
      seed = lcg_next(seed);
      ddr_is_ready = seed[16 +: NUM_CHAN];
      enable_channels('1);
      wait_for_done('1, DONE_WAIT, 1'b1);
      @(negedge clk);
      check_bursts('1);
      check_value("scrb_done", 64'(scrb_done), 64'({NUM_CHAN{1'b1}}));
      // only channel 0 keeps its final address
      enable_channels(NUM_CHAN'(1));
      // out of range select falls back to channel 0
      ctl0.dbg_en  = 1'b1;
      ctl0.dbg_sel = 3'd5;
      repeat (3) @(negedge clk);
      check_value("id0", 64'(id0), 64'(last[31:0]));
      check_value("id1", 64'(id1), 64'(last[63:32]));
      idle_inputs();
      finish_test("random ready, all channels", err_start);
   endtask

   task automatic disable_rescrub_test();
      int          err_start;
      logic [63:0] last;
      err_start = errors;
      last = final_scrub_addr();
      mark_bursts();
      ddr_is_ready = '1;
      ctl0.dbg_en  = 1'b1;
      ctl0.dbg_sel = 3'd2;
      enable_channels(NUM_CHAN'(4));
      wait_for_done(NUM_CHAN'(4), DONE_WAIT, 1'b0);
      @(negedge clk);
      check_bursts(NUM_CHAN'(4));
      check_value("id0", 64'(id0), 64'(last[31:0]));
      enable_channels('0);
      repeat (3) @(negedge clk);
      check_value("scrb_done[2]", 64'(scrb_done[2]), 64'd0);
      check_value("id0", 64'(id0), 64'd0);
      check_value("id1", 64'(id1), 64'd0);
      // second pass over the same channel
      mark_bursts();
      enable_channels(NUM_CHAN'(4));
      wait_for_done(NUM_CHAN'(4), DONE_WAIT, 1'b0);
      @(negedge clk);
      check_bursts(NUM_CHAN'(4));
      check_value("id0", 64'(id0), 64'(last[31:0]));
      idle_inputs();
      finish_test("disable and rescrub", err_start);
   endtask

   task automatic flr_pulse_test();
      int err_start;
      int pulses;
      int first;
      err_start = errors;
      pulses = 0;
      first = 0;
      flr_assert = 1'b1;
      for (int c = 1; c <= 12; c++)
      begin
         @(negedge clk);
         flr_assert = 1'b0;
         if (flr_done)
         begin
            pulses++;
            if (first == 0)
            begin
               first = c;
            end
         end
      end
      check_value("flr_done pulses", 64'(pulses), 64'd1);
      if (first == 0 || first > 3)
      begin
         $display("ERROR at %0d ns: flr_done did not pulse within 3 cycles", $time);
         errors++;
      end
      finish_test("FLR acknowledge", err_start);
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial
   begin
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      seed         = 32'h7ad7;
      sync_rst_n   = 1'b0;
      ctl0         = '0;
      ddr_is_ready = '0;
      flr_assert   = 1'b0;
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         burst_cnt[i]  = 0;
         burst_base[i] = 0;
      end

      repeat (4) @(negedge clk);
      sync_rst_n = 1'b1;
      @(negedge clk);

      reset_state_test();
      single_channel_test();
      ready_low_test();
      random_ready_test();
      disable_rescrub_test();
      flr_pulse_test();

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display("TEST RESULT: PASS");
      end
      else
      begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== dram_scrub.f ====
verilog/scrub_pkg.sv
verilog/scrub_ctl.sv
verilog/ddr_scrubber.sv
verilog/scrub_debug_mux.sv
verilog/dram_scrub_top.sv
bench/tb_dram_scrub.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the DRAM scrub testbench with Verilator and run it.
# Exits non-zero unless the testbench reports a pass.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_dram_scrub \
   --Mdir obj_dir \
   -f dram_scrub.f

sim_out="$(./obj_dir/Vtb_dram_scrub 2>&1)" || true
echo "$sim_out"

if grep -q "TEST RESULT: PASS" <<< "$sim_out"; then
   exit 0
else
   echo "simulation did not pass"
   exit 1
fi

// ==== verilog/ddr_scrubber.sv ====
/*
 * Address walker for one DRAM channel.
 * While enabled and the channel is ready, issues one burst per cycle,
 * strobing burst once per issue and stepping the address by the burst
 * size. The done flag rises the cycle after the last burst that fits
 * below SCRB_MAX_ADDR. Dropping enable returns the walker to address 0.
 */

`timescale 1ns/1ps

module ddr_scrubber #(
   parameter logic [scrub_pkg::ADDR_W-1:0] SCRB_MAX_ADDR         = 'h1FFF,
   parameter int                           SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                  clk,
   input  logic                  sync_rst_n,

   input  scrub_pkg::chan_ctl_t  chan_ctl,
   output logic                  burst,
   output scrub_pkg::scrb_stat_t stat
);

   import scrub_pkg::*;

   // bytes covered by one burst, one extra bit so the sum cannot wrap
   localparam logic [ADDR_W:0] BURST_BYTES =
      (ADDR_W + 1)'((SCRB_BURST_LEN_MINUS1 + 1) * BEAT_BYTES);

   logic [ADDR_W:0] next_addr;
   logic            at_end;
   logic            last_pend;
   logic            issue;

   // ------------------------------------------------------------------------
   // burst decision
   // ------------------------------------------------------------------------
   assign next_addr = {1'b0, stat.addr} + BURST_BYTES;

   // current burst is the last one that fits
   assign at_end = next_addr > {1'b0, SCRB_MAX_ADDR};

   assign issue = chan_ctl.ddr_ready && !stat.done && !last_pend;

   // ------------------------------------------------------------------------
   // walker state
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         burst     <= 1'b0;
         last_pend <= 1'b0;
         stat      <= '0;
      end
      else if (!chan_ctl.enable)
      begin
         // idle channel sits at the bottom of its range
         burst     <= 1'b0;
         last_pend <= 1'b0;
         stat      <= '0;
      end
      else
      begin
         burst <= issue;

         // set on the edge that issues the last burst, done follows
         last_pend <= issue && at_end;

         // addr holds on the last burst so it shows the final address
         if (issue && !at_end)
         begin
            stat.addr <= next_addr[ADDR_W-1:0];
         end

         if (last_pend)
         begin
            stat.done <= 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------
   // the walker never steps past the end of its range
   a_addr_in_range : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      stat.addr <= SCRB_MAX_ADDR
   ) else $error("scrub address 0x%0h beyond range", stat.addr);

   // no burst goes out once the channel has finished
   a_no_burst_when_done : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      burst |-> !stat.done
   ) else $error("burst strobe while done is set");

endmodule

// ==== verilog/dram_scrub_top.sv ====
/*
 * Top level of the DRAM scrub control path.
 * Connects the control register stage, one scrubber per channel and the
 * debug readout. NUM_CHAN may be 1 to 4. The scrub range and burst length
 * are set here and passed down to every scrubber.
 */

`timescale 1ns/1ps

module dram_scrub_top #(
   parameter int                           NUM_CHAN              = 4,
   parameter logic [scrub_pkg::ADDR_W-1:0] SCRB_MAX_ADDR         = 'h1FFF,
   parameter int                           SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                          clk,
   input  logic                          sync_rst_n,

   // control inputs
   input  scrub_pkg::ctl_word_t          ctl0,
   input  logic [NUM_CHAN-1:0]           ddr_is_ready,
   input  logic                          flr_assert,
   output logic                          flr_done,

   // scrub status
   output wire [NUM_CHAN-1:0]            scrb_burst,
   output logic [NUM_CHAN-1:0]           scrb_done,

   // ID / debug readout
   output logic [scrub_pkg::ID_W-1:0]    id0,
   output logic [scrub_pkg::ID_W-1:0]    id1
);

   import scrub_pkg::*;

   wire chan_ctl_t  [NUM_CHAN-1:0] chan_ctl;
   wire scrb_stat_t [NUM_CHAN-1:0] stat;
   logic                           dbg_en;
   logic [2:0]                     dbg_sel;

   // ------------------------------------------------------------------------
   // control registers
   // ------------------------------------------------------------------------
   scrub_ctl #(
      .NUM_CHAN     (NUM_CHAN)
   ) u_ctl (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .chan_ctl     (chan_ctl),
      .dbg_en       (dbg_en),
      .dbg_sel      (dbg_sel)
   );

   // ------------------------------------------------------------------------
   // one scrubber per channel
   // ------------------------------------------------------------------------
   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_scrb
      ddr_scrubber #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      ) u_scrb (
         .clk                   (clk),
         .sync_rst_n            (sync_rst_n),
         .chan_ctl              (chan_ctl[i]),
         .burst                 (scrb_burst[i]),
         .stat                  (stat[i])
      );
   end

   // ------------------------------------------------------------------------
   // debug readout and done vector
   // ------------------------------------------------------------------------
   scrub_debug_mux #(
      .NUM_CHAN   (NUM_CHAN)
   ) u_dbg (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .dbg_en     (dbg_en),
      .dbg_sel    (dbg_sel),
      .stat       (stat),
      .id0        (id0),
      .id1        (id1),
      .scrb_done  (scrb_done)
   );

endmodule

// ==== verilog/scrub_ctl.sv ====
/*
 * Control register stage for the scrub path.
 * Registers the control word, the per-channel DDR-ready bits and the
 * FLR request once, then fans the enables and ready bits out as one
 * control struct per scrubber. Also produces the FLR acknowledge pulse
 * and the registered debug select for the readout mux.
 */

`timescale 1ns/1ps

module scrub_ctl #(
   parameter int NUM_CHAN = 4
)
(
   input  logic                                  clk,
   input  logic                                  sync_rst_n,

   input  scrub_pkg::ctl_word_t                  ctl0,
   input  logic [NUM_CHAN-1:0]                   ddr_is_ready,
   input  logic                                  flr_assert,
   output logic                                  flr_done,

   output scrub_pkg::chan_ctl_t [NUM_CHAN-1:0]   chan_ctl,
   output logic                                  dbg_en,
   output logic [2:0]                            dbg_sel
);

   import scrub_pkg::*;

   ctl_word_t           ctl_q;
   logic [NUM_CHAN-1:0] ready_q;
   logic                flr_q;

   // ------------------------------------------------------------------------
   // input registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q   <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl_q   <= ctl0;
         ready_q <= ddr_is_ready;
      end
   end

   // ------------------------------------------------------------------------
   // FLR acknowledge
   // ------------------------------------------------------------------------
   // one pulse per registered request, toggles while the request is held
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end
   end

   // ------------------------------------------------------------------------
   // per-channel fan-out
   // ------------------------------------------------------------------------
   // enable bits above NUM_CHAN are ignored
   always_comb
   begin
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         chan_ctl[i].enable    = ctl_q.chan_en[i];
         chan_ctl[i].ddr_ready = ready_q[i];
      end
   end

   assign dbg_en  = ctl_q.dbg_en;
   assign dbg_sel = ctl_q.dbg_sel;

endmodule

// ==== verilog/scrub_debug_mux.sv ====
/*
 * Debug readout for the scrubbers.
 * With debug on, id0/id1 carry the low and high halves of the selected
 * channel's scrub address, one cycle late. With debug off they carry the
 * fixed device IDs. Also collects the per-channel done flags.
 */

`timescale 1ns/1ps

module scrub_debug_mux #(
   parameter int NUM_CHAN = 4
)
(
   input  logic                                   clk,
   input  logic                                   sync_rst_n,

   input  logic                                   dbg_en,
   input  logic [2:0]                             dbg_sel,
   input  scrub_pkg::scrb_stat_t [NUM_CHAN-1:0]   stat,

   output logic [scrub_pkg::ID_W-1:0]             id0,
   output logic [scrub_pkg::ID_W-1:0]             id1,
   output logic [NUM_CHAN-1:0]                    scrb_done
);

   import scrub_pkg::*;

   logic [ADDR_W-1:0] sel_addr;

   // ------------------------------------------------------------------------
   // channel select
   // ------------------------------------------------------------------------
   // out of range selects fall back to channel 0
   always_comb
   begin
      sel_addr = stat[0].addr;
      for (int i = 1; i < NUM_CHAN; i++)
      begin
         if (int'(dbg_sel) == i)
         begin
            sel_addr = stat[i].addr;
         end
      end
   end

   // ------------------------------------------------------------------------
   // registered ID outputs
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= DEV_ID0;
         id1 <= DEV_ID1;
      end
      else if (dbg_en)
      begin
         id0 <= sel_addr[ID_W-1:0];
         id1 <= sel_addr[ADDR_W-1:ID_W];
      end
      else
      begin
         id0 <= DEV_ID0;
         id1 <= DEV_ID1;
      end
   end

   // done flags go straight out
   always_comb
   begin
      for (int i = 0; i < NUM_CHAN; i++)
      begin
         scrb_done[i] = stat[i].done;
      end
   end

   // select comes from the control register, so it must be clean once used
   a_sel_known : assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      dbg_en |-> !$isunknown(dbg_sel)
   ) else $error("debug select has unknown bits");

endmodule

// ==== verilog/scrub_pkg.sv ====
/*
 * Shared definitions for the DRAM scrub control path.
 * Holds the widths, the layout of the control word, the fixed device
 * IDs and the per-channel structs that travel between the control
 * block, the scrubbers and the debug readout.
 */

package scrub_pkg;

   // ------------------------------------------------------------------------
   // widths and sizes
   // ------------------------------------------------------------------------
   localparam int MAX_CHAN   = 4;
   localparam int ADDR_W     = 64;
   localparam int ID_W       = 32;
   localparam int BEAT_BYTES = 64;

   // IDs shown on id0/id1 while debug readout is off
   localparam logic [ID_W-1:0] DEV_ID0 = 32'h0D5C_7A11;
   localparam logic [ID_W-1:0] DEV_ID1 = 32'h0D5C_0001;

   // ------------------------------------------------------------------------
   // control word
   // ------------------------------------------------------------------------
   // bit 31 debug enable, 30:28 debug channel select, 3:0 scrub enables
   typedef struct packed {
      logic                dbg_en;
      logic [2:0]          dbg_sel;
      logic [23:0]         rsvd;
      logic [MAX_CHAN-1:0] chan_en;
   } ctl_word_t;

   // one channel's control as seen by its scrubber
   typedef struct packed {
      logic enable;
      logic ddr_ready;
   } chan_ctl_t;

   // one channel's scrub state
   // addr is the next burst address, and holds the last one once done
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              done;
   } scrb_stat_t;

endpackage
